/* src/armPkg.sv */
package armPkg;

  typedef logic [31:0] wordT;
  typedef logic [3:0]  flagsT;     // N Z C V, N on top
  typedef logic [3:0]  opcodeT;    // Instruction bits 24:21
  typedef logic [4:0]  regOffsetT; // Byte offset inside the register window

  // Data-processing opcodes in ARM encoding order
  localparam opcodeT opAnd = 4'd0;
  localparam opcodeT opEor = 4'd1;
  localparam opcodeT opSub = 4'd2;
  localparam opcodeT opRsb = 4'd3;
  localparam opcodeT opAdd = 4'd4;
  localparam opcodeT opAdc = 4'd5;
  localparam opcodeT opSbc = 4'd6;
  localparam opcodeT opRsc = 4'd7;
  localparam opcodeT opTst = 4'd8;
  localparam opcodeT opTeq = 4'd9;
  localparam opcodeT opCmp = 4'd10;
  localparam opcodeT opCmn = 4'd11;
  localparam opcodeT opOrr = 4'd12;
  localparam opcodeT opMov = 4'd13;
  localparam opcodeT opBic = 4'd14;
  localparam opcodeT opMvn = 4'd15;

  // APB register map
  localparam regOffsetT regRn     = 5'h00;
  localparam regOffsetT regRm     = 5'h04;
  localparam regOffsetT regRs     = 5'h08;
  localparam regOffsetT regInstr  = 5'h0C;
  localparam regOffsetT regResult = 5'h10; // Read only
  localparam regOffsetT regFlags  = 5'h14;

endpackage

/* src/shifter.sv */
module shifter (
  input  armPkg::wordT instr,
  input  armPkg::wordT rm,
  input  armPkg::wordT rs,
  input  logic         carryIn,
  output armPkg::wordT operand2,
  output logic         carryOut
);

  logic [1:0]  shiftType;
  logic [7:0]  amount;
  logic [32:0] shiftLeft;
  logic [32:0] shiftRight;
  logic [32:0] shiftArith;
  logic [63:0] rotated;
  logic [4:0]  immRotate;
  logic [63:0] immRotated;

  assign shiftType = instr[6:5];

  // Immediate and register shifts share one datapath
  always_comb begin
    if (instr[4]) begin
      amount = rs[7:0];
    end else if (instr[11:7] == 5'd0 && (shiftType == 2'b01 || shiftType == 2'b10)) begin
      amount = 8'd32; // LSR #0 and ASR #0 encode 32
    end else begin
      amount = {3'b000, instr[11:7]};
    end
  end

  // Extra bit catches the last bit shifted out
  assign shiftLeft  = {1'b0, rm} << amount;
  assign shiftRight = {rm, 1'b0} >> amount;
  assign shiftArith = $signed({rm, 1'b0}) >>> amount;
  assign rotated    = {rm, rm} >> amount[4:0];

  assign immRotate  = {instr[11:8], 1'b0};
  assign immRotated = {24'd0, instr[7:0], 24'd0, instr[7:0]} >> immRotate;

  always_comb begin
    operand2 = rm;
    carryOut = carryIn;
    if (instr[25]) begin
      operand2 = immRotated[31:0];
      if (instr[11:8] != 4'd0) begin
        carryOut = immRotated[31];
      end
    end else if (!instr[4] && shiftType == 2'b11 && instr[11:7] == 5'd0) begin
      operand2 = {carryIn, rm[31:1]}; // RRX
      carryOut = rm[0];
    end else if (amount != 8'd0) begin
      case (shiftType)
        2'b00: begin // LSL
          operand2 = shiftLeft[31:0];
          carryOut = shiftLeft[32];
        end
        2'b01: begin // LSR
          operand2 = shiftRight[32:1];
          carryOut = shiftRight[0];
        end
        2'b10: begin // ASR, saturates to the sign
          operand2 = shiftArith[32:1];
          carryOut = shiftArith[0];
        end
        default: begin // ROR, multiples of 32 give rm back
          operand2 = rotated[31:0];
          carryOut = rotated[31];
        end
      endcase
    end
  end

  // Register shift by zero must leave rm untouched whatever the type
  always_comb begin
    if (!instr[25] && instr[4] && rs[7:0] == 8'd0) begin
      assert (operand2 == rm)
        else $error("shifter: zero register shift altered operand");
    end
  end

endmodule

/* src/alu.sv */
module alu (
  input  armPkg::opcodeT opcode,
  input  armPkg::wordT   rn,
  input  armPkg::wordT   operand2,
  input  logic           shifterCarry,
  input  armPkg::flagsT  flagsIn,
  output armPkg::wordT   aluResult,
  output armPkg::flagsT  aluFlags,
  output logic           writesResult
);

  armPkg::wordT addA;
  armPkg::wordT addB;
  logic         addCin;
  logic         isArith;
  logic [32:0]  sum;
  logic         overflow;
  armPkg::wordT value;

  // Operand select for the shared adder
  always_comb begin
    addA    = rn;
    addB    = operand2;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (opcode)
      armPkg::opSub, armPkg::opCmp: begin
        addB   = ~operand2;
        addCin = 1'b1;
      end
      armPkg::opRsb: begin
        addA   = operand2;
        addB   = ~rn;
        addCin = 1'b1;
      end
      armPkg::opAdd, armPkg::opCmn: begin
        addCin = 1'b0;
      end
      armPkg::opAdc: begin
        addCin = flagsIn[1];
      end
      armPkg::opSbc: begin
        addB   = ~operand2;
        addCin = flagsIn[1]; // Borrow is not C
      end
      armPkg::opRsc: begin
        addA   = operand2;
        addB   = ~rn;
        addCin = flagsIn[1];
      end
      default: isArith = 1'b0;
    endcase
  end

  assign sum      = {1'b0, addA} + {1'b0, addB} + {32'd0, addCin};
  assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

  always_comb begin
    case (opcode)
      armPkg::opAnd, armPkg::opTst: value = rn & operand2;
      armPkg::opEor, armPkg::opTeq: value = rn ^ operand2;
      armPkg::opOrr:                value = rn | operand2;
      armPkg::opMov:                value = operand2;
      armPkg::opBic:                value = rn & ~operand2;
      armPkg::opMvn:                value = ~operand2;
      default:                      value = sum[31:0];
    endcase
  end

  assign aluResult = value;

  // Compare and test ops only touch the flags
  assign writesResult = !(opcode == armPkg::opTst || opcode == armPkg::opTeq ||
                          opcode == armPkg::opCmp || opcode == armPkg::opCmn);

  assign aluFlags = {value[31],
                     value == '0,
                     isArith ? sum[32] : shifterCarry,
                     isArith ? overflow : flagsIn[0]};

endmodule

/* src/executeUnit.sv */
module executeUnit (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  input  armPkg::wordT  instr,
  input  armPkg::wordT  rn,
  input  armPkg::wordT  rm,
  input  armPkg::wordT  rs,
  input  logic          flagsWrite,
  input  armPkg::flagsT flagsWriteData,
  output armPkg::wordT  result,
  output armPkg::flagsT flags
);

  armPkg::opcodeT opcode;
  armPkg::wordT   operand2;
  logic           shifterCarry;
  armPkg::wordT   aluResult;
  armPkg::flagsT  aluFlags;
  logic           writesResult;

  assign opcode = instr[24:21];

  shifter shifterInst (
    .instr    (instr),
    .rm       (rm),
    .rs       (rs),
    .carryIn  (flags[1]),
    .operand2 (operand2),
    .carryOut (shifterCarry)
  );

  alu aluInst (
    .opcode       (opcode),
    .rn           (rn),
    .operand2     (operand2),
    .shifterCarry (shifterCarry),
    .flagsIn      (flags),
    .aluResult    (aluResult),
    .aluFlags     (aluFlags),
    .writesResult (writesResult)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      flags  <= '0;
    end else begin
      if (start && writesResult) begin
        result <= aluResult;
      end
      if (start && instr[20]) begin // S bit, wins over a bus write
        flags <= aluFlags;
      end else if (flagsWrite) begin
        flags <= flagsWriteData;
      end
    end
  end

  // Each instruction needs its own APB write, so start is a lone pulse
  startSinglePulse: assert property (@(posedge clk) disable iff (reset) start |=> !start)
    else $error("executeUnit: start high on consecutive cycles");

endmodule

/* src/apbRegs.sv */
module apbRegs #(
  parameter int addrWidth = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [addrWidth-1:0] paddr,
  input  armPkg::wordT         pwdata,
  output armPkg::wordT         prdata,
  output logic                 pready,
  output logic                 pslverr,
  output armPkg::wordT         rn,
  output armPkg::wordT         rm,
  output armPkg::wordT         rs,
  output armPkg::wordT         instr,
  output logic                 start,
  output logic                 flagsWrite,
  output armPkg::flagsT        flagsWriteData,
  input  armPkg::wordT         result,
  input  armPkg::flagsT        flags
);

  logic              access;
  logic              inRange;
  armPkg::regOffsetT offset;
  logic              readHit;
  logic              writeHit;
  logic              writeEn;
  armPkg::wordT      readData;

  assign access  = psel && penable;
  assign offset  = paddr[4:0];
  assign inRange = (paddr >> 5) == '0; // Window is the low 32 bytes

  // Unaligned offsets fall through to the default
  always_comb begin
    readData = '0;
    readHit  = 1'b1;
    case (offset)
      armPkg::regRn:     readData = rn;
      armPkg::regRm:     readData = rm;
      armPkg::regRs:     readData = rs;
      armPkg::regInstr:  readData = instr;
      armPkg::regResult: readData = result;
      armPkg::regFlags:  readData = {28'd0, flags};
      default:           readHit  = 1'b0;
    endcase
  end

  assign writeHit = readHit && offset != armPkg::regResult;

  assign pready  = 1'b1; // No wait states
  assign pslverr = access && !(inRange && (pwrite ? writeHit : readHit));
  assign prdata  = (inRange && readHit && !pslverr) ? readData : '0;
  assign writeEn = access && pwrite && !pslverr;

  // Flags live in the execute unit
  assign flagsWrite     = writeEn && offset == armPkg::regFlags;
  assign flagsWriteData = pwdata[3:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      rn    <= '0;
      rm    <= '0;
      rs    <= '0;
      instr <= '0;
      start <= 1'b0;
    end else begin
      start <= writeEn && offset == armPkg::regInstr;
      if (writeEn && offset == armPkg::regRn) begin
        rn <= pwdata;
      end
      if (writeEn && offset == armPkg::regRm) begin
        rm <= pwdata;
      end
      if (writeEn && offset == armPkg::regRs) begin
        rs <= pwdata;
      end
      if (writeEn && offset == armPkg::regInstr) begin
        instr <= pwdata;
      end
    end
  end

  // Access phase only ever follows a setup with psel held
  penableNeedsPsel: assert property (@(posedge clk) disable iff (reset) penable |-> psel)
    else $error("apbRegs: penable without psel");

endmodule

/* src/dpAccel.sv */
module dpAccel #(
  parameter int addrWidth = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [addrWidth-1:0] paddr,
  input  armPkg::wordT         pwdata,
  output armPkg::wordT         prdata,
  output logic                 pready,
  output logic                 pslverr
);

  armPkg::wordT  rn;
  armPkg::wordT  rm;
  armPkg::wordT  rs;
  armPkg::wordT  instr;
  logic          start;
  logic          flagsWrite;
  armPkg::flagsT flagsWriteData;
  armPkg::wordT  result;
  armPkg::flagsT flags;

  apbRegs #(
    .addrWidth (addrWidth)
  ) apbRegsInst (
    .clk            (clk),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .rn             (rn),
    .rm             (rm),
    .rs             (rs),
    .instr          (instr),
    .start          (start),
    .flagsWrite     (flagsWrite),
    .flagsWriteData (flagsWriteData),
    .result         (result),
    .flags          (flags)
  );

  executeUnit executeUnitInst (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .instr          (instr),
    .rn             (rn),
    .rm             (rm),
    .rs             (rs),
    .flagsWrite     (flagsWrite),
    .flagsWriteData (flagsWriteData),
    .result         (result),
    .flags          (flags)
  );

endmodule

/* bench/dpAccelTb.sv */
module dpAccelTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int addrWidth   = 8;
  localparam int numImmShift = 300;
  localparam int numRegShift = 300;
  localparam int numAllOps   = 400;
  // Seven transfers per instruction, the rest covers the register and error tests
  localparam int totalTransfers = 7 * (numImmShift + numRegShift + numAllOps) + 60;
  localparam int watchdogCycles = 3 * totalTransfers + 100;
  localparam armPkg::regOffsetT allRegs [6] = '{armPkg::regRn, armPkg::regRm, armPkg::regRs,
    armPkg::regInstr, armPkg::regResult, armPkg::regFlags};
  localparam logic [addrWidth-1:0] badAddrs [8] = '{8'h01, 8'h06, 8'h0F, 8'h13, 8'h18, 8'h1C,
    8'h20, 8'h94};

  logic                 clk;
  logic                 reset;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [addrWidth-1:0] paddr;
  armPkg::wordT         pwdata;
  armPkg::wordT         prdata;
  logic                 pready;
  logic                 pslverr;

  logic [31:0]   lfsrState;
  int            errors;
  int            testsPassed;
  int            testsFailed;
  armPkg::wordT  modelRn;
  armPkg::wordT  modelRm;
  armPkg::wordT  modelRs;
  armPkg::wordT  modelInstr;
  armPkg::wordT  modelResult;
  armPkg::flagsT modelFlags;

  dpAccel #(.addrWidth(addrWidth)) dut (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdogCycles * 10);
    $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] randBits(input int width);
    logic [31:0] value;
    logic        feedback;
    int          i;
    value = '0;
    for (i = 0; i < width; i++) begin
      feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      value     = {value[30:0], feedback};
    end
    return value;
  endfunction

  task automatic checkWord(input string what, input armPkg::wordT expected,
                           input armPkg::wordT actual);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, what, expected, actual);
      errors++;
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    if (errors == errorsBefore) begin
      testsPassed++;
      $display("%s: passed", name);
    end else begin
      testsFailed++;
      $display("%s: failed with %0d errors", name, errors - errorsBefore);
    end
  endtask

  task automatic busTransfer(input logic write, input logic [addrWidth-1:0] addr,
                             input armPkg::wordT data, output armPkg::wordT rdata,
                             output logic err);
    @(posedge clk);
    psel   <= 1'b1;
    pwrite <= write;
    paddr  <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk); // Mid access cycle
    rdata = prdata;
    err   = pslverr;
    checkWord($sformatf("pready in access to 0x%h", addr), 32'd1, 32'(pready));
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input armPkg::regOffsetT offset, input armPkg::wordT data);
    armPkg::wordT unused;
    logic         err;
    busTransfer(1'b1, addrWidth'(offset), data, unused, err);
    checkWord($sformatf("pslverr on write to 0x%h", offset), '0, 32'(err));
  endtask

  task automatic apbRead(input armPkg::regOffsetT offset, output armPkg::wordT data);
    logic err;
    busTransfer(1'b0, addrWidth'(offset), '0, data, err);
    checkWord($sformatf("pslverr on read of 0x%h", offset), '0, 32'(err));
  endtask

  // Returns {carry, operand 2}
  function automatic logic [32:0] shiftModel(input armPkg::wordT instr, input armPkg::wordT rm,
                                             input armPkg::wordT rs, input logic carryIn);
    int           amount;
    armPkg::wordT imm;
    armPkg::wordT op2;
    armPkg::wordT lastOut;
    if (instr[25]) begin
      amount = 2 * int'(instr[11:8]);
      imm    = {24'd0, instr[7:0]};
      op2    = (imm >> amount) | (imm << (32 - amount));
      return {(amount == 0) ? carryIn : op2[31], op2};
    end
    amount = instr[4] ? int'(rs[7:0]) : int'(instr[11:7]);
    if (!instr[4] && amount == 0 && instr[6:5] == 2'b11) begin
      return {rm[0], carryIn, rm[31:1]}; // RRX
    end
    if (!instr[4] && amount == 0 && instr[6:5] != 2'b00) begin
      amount = 32;
    end
    if (amount == 0) begin
      return {carryIn, rm};
    end
    case (instr[6:5])
      2'b00: begin
        lastOut = rm << (amount - 1);
        return (amount > 32) ? 33'd0 : {lastOut[31], rm << amount};
      end
      2'b01: begin
        lastOut = rm >> (amount - 1);
        return (amount > 32) ? 33'd0 : {lastOut[0], rm >> amount};
      end
      2'b10: begin
        lastOut = rm >> (amount - 1);
        return (amount >= 32) ? {rm[31], {32{rm[31]}}} : {lastOut[0], $signed(rm) >>> amount};
      end
      default: begin
        amount  = amount % 32;
        lastOut = rm >> (amount - 1);
        return (amount == 0) ? {rm[31], rm} :
          {lastOut[0], (rm >> amount) | (rm << (32 - amount))};
      end
    endcase
  endfunction

  // Returns {flags, result}
  function automatic logic [35:0] execModel(input armPkg::wordT instr, input armPkg::wordT rn,
      input armPkg::wordT rm, input armPkg::wordT rs, input armPkg::flagsT flagsIn,
      input armPkg::wordT prevResult);
    logic [32:0]    shifted;
    armPkg::opcodeT opcode;
    armPkg::wordT   a;
    armPkg::wordT   b;
    armPkg::wordT   value;
    logic [63:0]    wide;
    logic           c;
    logic           v;
    logic           subtract;
    logic           swap;
    shifted  = shiftModel(instr, rm, rs, flagsIn[1]);
    opcode   = instr[24:21];
    swap     = opcode == armPkg::opRsb || opcode == armPkg::opRsc;
    a        = swap ? shifted[31:0] : rn;
    b        = swap ? rn : shifted[31:0];
    c        = shifted[32];
    v        = flagsIn[0];
    subtract = 1'b1;
    wide     = '0;
    case (opcode)
      armPkg::opAnd, armPkg::opTst: value = rn & b;
      armPkg::opEor, armPkg::opTeq: value = rn ^ b;
      armPkg::opOrr: value = rn | b;
      armPkg::opMov: value = b;
      armPkg::opBic: value = rn & ~b;
      armPkg::opMvn: value = ~b;
      default: begin
        if (opcode == armPkg::opAdd || opcode == armPkg::opCmn || opcode == armPkg::opAdc) begin
          subtract = 1'b0;
          wide = 64'(a) + 64'(b) + ((opcode == armPkg::opAdc) ? 64'(flagsIn[1]) : 64'd0);
        end else if (opcode == armPkg::opSbc || opcode == armPkg::opRsc) begin
          wide = 64'(a) - 64'(b) - 64'(!flagsIn[1]);
        end else begin
          wide = 64'(a) - 64'(b);
        end
        value = wide[31:0];
        c = subtract ? !wide[63] : wide[32]; // Borrow shows as a negative difference
        v = ((a[31] ^ b[31]) == subtract) && (value[31] != a[31]);
      end
    endcase
    return {instr[20] ? {value[31], value == '0, c, v} : flagsIn,
            (opcode inside {armPkg::opTst, armPkg::opTeq, armPkg::opCmp, armPkg::opCmn}) ?
              prevResult : value};
  endfunction

  function automatic armPkg::wordT makeInstr(input armPkg::opcodeT opcode, input logic setFlags,
                                             input logic imm, input logic regShift);
    armPkg::wordT instr;
    instr = randBits(32);
    instr[31:20] = {4'hE, 2'b00, imm, opcode, setFlags};
    if (!imm) begin
      instr[7:4] = regShift ? {1'b0, instr[6:5], 1'b1} : {instr[7:5], 1'b0};
    end
    return instr;
  endfunction

  task automatic runInstr(input armPkg::wordT instr, input armPkg::wordT rsVal);
    logic [35:0]  expected;
    armPkg::wordT readBack;
    modelRn    = randBits(32);
    modelRm    = randBits(32);
    modelRs    = rsVal;
    modelFlags = 4'(randBits(4)); // Random preset flags
    modelInstr = instr;
    apbWrite(armPkg::regRn, modelRn);
    apbWrite(armPkg::regRm, modelRm);
    apbWrite(armPkg::regRs, modelRs);
    apbWrite(armPkg::regFlags, 32'(modelFlags));
    apbWrite(armPkg::regInstr, instr);
    expected    = execModel(instr, modelRn, modelRm, modelRs, modelFlags, modelResult);
    modelResult = expected[31:0];
    modelFlags  = expected[35:32];
    apbRead(armPkg::regResult, readBack);
    checkWord($sformatf("result of instruction %h", instr), modelResult, readBack);
    apbRead(armPkg::regFlags, readBack);
    checkWord($sformatf("flags of instruction %h", instr), 32'(modelFlags), readBack);
  endtask

  task automatic checkAllRegs(input string label);
    armPkg::wordT expected [6];
    armPkg::wordT readBack;
    int           i;
    expected = '{modelRn, modelRm, modelRs, modelInstr, modelResult, 32'(modelFlags)};
    for (i = 0; i < 6; i++) begin
      apbRead(allRegs[i], readBack);
      checkWord($sformatf("%s register 0x%h", label, allRegs[i]), expected[i], readBack);
    end
  endtask

  initial begin
    int           errorsBefore;
    int           n;
    armPkg::wordT instr;
    armPkg::wordT rsVal;
    armPkg::wordT rdata;
    logic         err;
    lfsrState   = 32'h2877fb19;
    errors      = 0;
    testsPassed = 0;
    testsFailed = 0;
    {modelRn, modelRm, modelRs, modelInstr, modelResult, modelFlags} = '0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    errorsBefore = errors;
    checkAllRegs("reset value of");
    modelRn = randBits(32);
    apbWrite(armPkg::regRn, modelRn);
    modelRm = randBits(32);
    apbWrite(armPkg::regRm, modelRm);
    modelRs = randBits(32);
    apbWrite(armPkg::regRs, modelRs);
    rdata = randBits(32);
    apbWrite(armPkg::regFlags, rdata);
    modelFlags = rdata[3:0];
    checkAllRegs("written");
    finishTest("Test 1 reset and register read-back", errorsBefore);

    errorsBefore = errors;
    for (n = 0; n < numImmShift; n++) begin
      instr = makeInstr(armPkg::opMov, 1'b1, randBits(1) != 0, 1'b0);
      if (!instr[25] && randBits(2) == 0) begin
        instr[11:7] = 5'd0; // LSR #32, ASR #32 and RRX encodings
      end
      runInstr(instr, randBits(32));
    end
    finishTest("Test 2 immediate and immediate-shift operand", errorsBefore);

    errorsBefore = errors;
    for (n = 0; n < numRegShift; n++) begin
      instr = makeInstr(armPkg::opMov, 1'b1, 1'b0, 1'b1);
      rsVal = randBits(32);
      case (randBits(2))
        0: rsVal[7:0] = 8'd0;
        1: rsVal[7:0] = 8'd32;
        2: rsVal[7:0] = 8'(randBits(8)) | 8'd32;
        default: ;
      endcase
      runInstr(instr, rsVal);
    end
    finishTest("Test 3 register-shift operand", errorsBefore);

    errorsBefore = errors;
    for (n = 0; n < numAllOps; n++) begin
      instr = makeInstr(4'(randBits(4)), randBits(1) != 0, randBits(1) != 0, randBits(1) != 0);
      runInstr(instr, randBits(32));
    end
    finishTest("Test 4 all opcodes", errorsBefore);

    errorsBefore = errors;
    for (n = 0; n < 8; n++) begin
      busTransfer(1'b1, badAddrs[n], randBits(32), rdata, err);
      checkWord($sformatf("pslverr on write to 0x%h", badAddrs[n]), 32'd1, 32'(err));
      checkWord($sformatf("prdata on write to 0x%h", badAddrs[n]), '0, rdata);
      busTransfer(1'b0, badAddrs[n], '0, rdata, err);
      checkWord($sformatf("pslverr on read of 0x%h", badAddrs[n]), 32'd1, 32'(err));
      checkWord($sformatf("prdata on read of 0x%h", badAddrs[n]), '0, rdata);
    end
    busTransfer(1'b1, addrWidth'(armPkg::regResult), randBits(32), rdata, err);
    checkWord("pslverr on write to result", 32'd1, 32'(err));
    checkWord("prdata on write to result", '0, rdata);
    checkAllRegs("after rejected writes,");
    finishTest("Test 5 APB errors", errorsBefore);

    $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/armPkg.sv
src/shifter.sv
src/alu.sv
src/executeUnit.sv
src/apbRegs.sv
src/dpAccel.sv
bench/dpAccelTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module dpAccelTb \
  -f verilog.f -Mdir obj_dir -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
